/* dma_macros.svh */
// DMA mux sizing macros

`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Region count and region number width
`define N_REGIONS      4
`define N_REGIONS_BITS 2

// Request field widths
`define LEN_BITS       16
`define ADDR_BITS      48

// Data beat width and log2 of its byte count
`define DATA_BITS      64
`define BEAT_LOG_BITS  3

// Depth of routing and completion queues
`define N_OUTSTANDING  4

`endif

/* dma_req_pkg.sv */
// DMA request field types

`default_nettype none

`include "dma_macros.svh"

package dma_req_pkg;

    // Region number
    typedef logic [`N_REGIONS_BITS-1:0] vfid_t;

    // Byte length of one request
    typedef logic [`LEN_BITS-1:0] len_t;

    // Start address of one request
    typedef logic [`ADDR_BITS-1:0] addr_t;

endpackage

`default_nettype wire

/* stream_mux_pkg.sv */
// Stream routing types

`default_nettype none

`include "dma_macros.svh"

package stream_mux_pkg;

    // Beat count minus one
    typedef logic [`LEN_BITS-`BEAT_LOG_BITS-1:0] blen_t;

    // One data beat
    typedef logic [`DATA_BITS-1:0] data_t;

    // Router FSM states
    typedef enum logic {ROUTE_IDLE, ROUTE_BURST} route_state_e;

endpackage

`default_nettype wire

/* seq_fifo.sv */
// Sequence queue

`timescale 1ns/10ps
`default_nettype none

module seq_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire logic             aclk,
    input  wire logic             aresetn,
    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire logic [WIDTH-1:0] in_data,
    output logic                  out_valid,
    input  wire logic             out_ready,
    output logic [WIDTH-1:0]      out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage and pointers
    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Flags straight from occupancy
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head shows without a read cycle
    assign out_data = mem[rd_ptr];

    // --------------------
    // Pointers and count
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together keep the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry write
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* dma_arbiter.sv */
// Round-robin DMA request arbiter

`timescale 1ns/10ps
`default_nettype none

`include "dma_macros.svh"

module dma_arbiter (
    input  wire logic                                 aclk,
    input  wire logic                                 aresetn,
    // Region requests
    input  wire logic [`N_REGIONS-1:0]                s_req_valid,
    output logic [`N_REGIONS-1:0]                     s_req_ready,
    input  wire dma_req_pkg::addr_t [`N_REGIONS-1:0]  s_req_addr,
    input  wire dma_req_pkg::len_t [`N_REGIONS-1:0]   s_req_len,
    input  wire logic [`N_REGIONS-1:0]                s_req_last,
    // Engine request port
    output logic                                      m_req_valid,
    input  wire logic                                 m_req_ready,
    output dma_req_pkg::addr_t                        m_req_addr,
    output dma_req_pkg::len_t                         m_req_len,
    output logic                                      m_req_last,
    // Routing queue push
    output logic                                      route_valid,
    input  wire logic                                 route_ready,
    output dma_req_pkg::vfid_t                        route_vfid,
    output logic                                      route_last,
    output stream_mux_pkg::blen_t                     route_blen,
    // Completion queue push
    output logic                                      done_valid,
    input  wire logic                                 done_ready,
    output dma_req_pkg::vfid_t                        done_vfid
);

    import dma_req_pkg::*;
    import stream_mux_pkg::*;

    // Round-robin pointer and current winner
    vfid_t rr_ptr;
    vfid_t grant_vfid;
    logic  grant_any;
    logic  queues_ready;
    logic  req_fire;
    len_t  len_m1;

    // Room in both queues needed before granting
    assign queues_ready = route_ready && done_ready;

    // --------------------
    // Search from pointer
    always_comb begin
        int idx;
        grant_any  = 1'b0;
        grant_vfid = rr_ptr;
        for (int i = 0; i < `N_REGIONS; i++) begin
            idx = (int'(rr_ptr) + i) % `N_REGIONS;
            // First requester after the pointer wins
            if (!grant_any && s_req_valid[idx]) begin
                grant_any  = 1'b1;
                grant_vfid = vfid_t'(idx);
            end
        end
    end

    // --------------------
    // Engine request
    assign m_req_valid = grant_any && queues_ready;
    assign m_req_addr  = s_req_addr[grant_vfid];
    assign m_req_len   = s_req_len[grant_vfid];
    // Engine always sees a closed request
    assign m_req_last  = 1'b1;
    assign req_fire    = m_req_valid && m_req_ready;

    // Ready only back to the granted region
    always_comb begin
        s_req_ready             = '0;
        s_req_ready[grant_vfid] = req_fire;
    end

    // --------------------
    // Queue entries
    assign len_m1      = s_req_len[grant_vfid] - len_t'(1);
    assign route_valid = req_fire;
    assign route_vfid  = grant_vfid;
    // Region last flag goes to the router
    assign route_last  = s_req_last[grant_vfid];
    assign route_blen  = blen_t'(len_m1 >> `BEAT_LOG_BITS);
    assign done_valid  = req_fire;
    assign done_vfid   = grant_vfid;

    // Pointer moves past the winner
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rr_ptr <= '0;
        end else if (req_fire) begin
            if (grant_vfid == vfid_t'(`N_REGIONS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= grant_vfid + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* stream_router.sv */
// Data beat router FSM

`timescale 1ns/10ps
`default_nettype none

`include "dma_macros.svh"

module stream_router (
    input  wire logic                                   aclk,
    input  wire logic                                   aresetn,
    // Routing queue head
    input  wire logic                                   route_valid,
    output logic                                        route_ready,
    input  wire dma_req_pkg::vfid_t                     route_vfid,
    input  wire logic                                   route_last,
    input  wire stream_mux_pkg::blen_t                  route_blen,
    // Engine data
    input  wire logic                                   s_dat_valid,
    output logic                                        s_dat_ready,
    input  wire stream_mux_pkg::data_t                  s_dat_data,
    // Region data
    output logic [`N_REGIONS-1:0]                       m_dat_valid,
    input  wire logic [`N_REGIONS-1:0]                  m_dat_ready,
    output stream_mux_pkg::data_t [`N_REGIONS-1:0]      m_dat_data,
    output logic [`N_REGIONS-1:0]                       m_dat_last
);

    import dma_req_pkg::*;
    import stream_mux_pkg::*;

    route_state_e state;
    vfid_t        cur_vfid;
    logic         cur_last;
    blen_t        beat_cnt;
    logic         last_beat;
    logic         beat_fire;

    // Counter at zero means final beat
    assign last_beat = (beat_cnt == '0);
    assign beat_fire = s_dat_valid && s_dat_ready;

    // --------------------
    // Demux
    always_comb begin
        route_ready = (state == ROUTE_IDLE);
        s_dat_ready = 1'b0;
        m_dat_valid = '0;
        m_dat_last  = '0;
        // Payload goes to every region and valid picks one
        for (int i = 0; i < `N_REGIONS; i++) begin
            m_dat_data[i] = s_dat_data;
        end
        if (state == ROUTE_BURST) begin
            s_dat_ready           = m_dat_ready[cur_vfid];
            m_dat_valid[cur_vfid] = s_dat_valid;
            m_dat_last[cur_vfid]  = cur_last && last_beat;
        end
    end

    // --------------------
    // State and beat counter
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= ROUTE_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ROUTE_IDLE: begin
                    // Pop one entry and load its count
                    if (route_valid) begin
                        beat_cnt <= route_blen;
                        state    <= ROUTE_BURST;
                    end
                end
                ROUTE_BURST: begin
                    if (beat_fire) begin
                        if (last_beat) begin
                            state <= ROUTE_IDLE;
                        end else begin
                            beat_cnt <= beat_cnt - 1'b1;
                        end
                    end
                end
                default: state <= ROUTE_IDLE;
            endcase
        end
    end

    // Entry region and flag
    always_ff @(posedge aclk) begin
        if (route_valid && route_ready) begin
            cur_vfid <= route_vfid;
            cur_last <= route_last;
        end
    end

endmodule

`default_nettype wire

/* dma_mux_top.sv */
// Multi-region DMA request front end

`timescale 1ns/10ps
`default_nettype none

`include "dma_macros.svh"

module dma_mux_top (
    input  wire logic                                  aclk,
    input  wire logic                                  aresetn,
    // Region requests
    input  wire logic [`N_REGIONS-1:0]                 s_req_valid,
    output logic [`N_REGIONS-1:0]                      s_req_ready,
    input  wire dma_req_pkg::addr_t [`N_REGIONS-1:0]   s_req_addr,
    input  wire dma_req_pkg::len_t [`N_REGIONS-1:0]    s_req_len,
    input  wire logic [`N_REGIONS-1:0]                 s_req_last,
    // Engine requests and completions
    output logic                                       m_req_valid,
    input  wire logic                                  m_req_ready,
    output dma_req_pkg::addr_t                         m_req_addr,
    output dma_req_pkg::len_t                          m_req_len,
    output logic                                       m_req_last,
    input  wire logic                                  m_rsp_done,
    output logic [`N_REGIONS-1:0]                      s_rsp_done,
    // Engine data
    input  wire logic                                  s_dat_valid,
    output logic                                       s_dat_ready,
    input  wire stream_mux_pkg::data_t                 s_dat_data,
    // Region data
    output logic [`N_REGIONS-1:0]                      m_dat_valid,
    input  wire logic [`N_REGIONS-1:0]                 m_dat_ready,
    output stream_mux_pkg::data_t [`N_REGIONS-1:0]     m_dat_data,
    output logic [`N_REGIONS-1:0]                      m_dat_last
);

    import dma_req_pkg::*;
    import stream_mux_pkg::*;

    // Routing entry is last flag, region and beat count
    localparam int ROUTE_W = 1 + $bits(vfid_t) + $bits(blen_t);

    // Arbiter to routing queue
    logic               route_in_valid;
    logic               route_in_ready;
    vfid_t              route_in_vfid;
    logic               route_in_last;
    blen_t              route_in_blen;
    // Routing queue to router
    logic               route_out_valid;
    logic               route_out_ready;
    logic [ROUTE_W-1:0] route_out_data;
    // Completion queue
    logic               done_in_valid;
    logic               done_in_ready;
    vfid_t              done_in_vfid;
    logic               done_head_valid;
    vfid_t              done_head_vfid;

    dma_arbiter u_dma_arbiter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req_addr  (s_req_addr),
        .s_req_len   (s_req_len),
        .s_req_last  (s_req_last),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_addr  (m_req_addr),
        .m_req_len   (m_req_len),
        .m_req_last  (m_req_last),
        .route_valid (route_in_valid),
        .route_ready (route_in_ready),
        .route_vfid  (route_in_vfid),
        .route_last  (route_in_last),
        .route_blen  (route_in_blen),
        .done_valid  (done_in_valid),
        .done_ready  (done_in_ready),
        .done_vfid   (done_in_vfid)
    );

    // --------------------
    // Routing queue
    seq_fifo #(
        .WIDTH (ROUTE_W),
        .DEPTH (`N_OUTSTANDING)
    ) u_route_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (route_in_valid),
        .in_ready  (route_in_ready),
        .in_data   ({route_in_last, route_in_vfid, route_in_blen}),
        .out_valid (route_out_valid),
        .out_ready (route_out_ready),
        .out_data  (route_out_data)
    );

    // --------------------
    // Completion queue popped by engine done
    seq_fifo #(
        .WIDTH ($bits(vfid_t)),
        .DEPTH (`N_OUTSTANDING)
    ) u_done_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (done_in_valid),
        .in_ready  (done_in_ready),
        .in_data   (done_in_vfid),
        .out_valid (done_head_valid),
        .out_ready (m_rsp_done),
        .out_data  (done_head_vfid)
    );

    // Done pulse to head region only
    always_comb begin
        for (int i = 0; i < `N_REGIONS; i++) begin
            s_rsp_done[i] = m_rsp_done && done_head_valid && (done_head_vfid == vfid_t'(i));
        end
    end

    stream_router u_stream_router (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .route_valid (route_out_valid),
        .route_ready (route_out_ready),
        .route_vfid  (route_out_data[$bits(blen_t) +: $bits(vfid_t)]),
        .route_last  (route_out_data[ROUTE_W-1]),
        .route_blen  (route_out_data[$bits(blen_t)-1:0]),
        .s_dat_valid (s_dat_valid),
        .s_dat_ready (s_dat_ready),
        .s_dat_data  (s_dat_data),
        .m_dat_valid (m_dat_valid),
        .m_dat_ready (m_dat_ready),
        .m_dat_data  (m_dat_data),
        .m_dat_last  (m_dat_last)
    );

endmodule

`default_nettype wire

/* tb_dma_mux_top.sv */
// DMA mux front end testbench

`timescale 1ns/10ps
`default_nettype none

`include "dma_macros.svh"

module tb_dma_mux_top;

    import dma_req_pkg::*;
    import stream_mux_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_ROWS     = 6;
    localparam int MAX_REQ    = N_ROWS * `N_REGIONS;
    localparam int MAX_BEATS  = 32;
    localparam int MAX_DELAY  = 40;
    localparam int IDX_W      = `DATA_BITS - `N_REGIONS_BITS;
    localparam int ADDR_LOW   = `ADDR_BITS - `N_REGIONS_BITS;
    // Worst case per request is a fully stalled burst plus its completion wait
    localparam int WATCHDOG_CYCLES = N_ROWS * `N_REGIONS * (MAX_BEATS * 4 + MAX_DELAY * 2) + 500;

    // One row of the stimulus table
    typedef struct packed {
        logic [`N_REGIONS-1:0] mask;
        len_t [`N_REGIONS-1:0] len;
        logic [`N_REGIONS-1:0] last;
        int                    stall;
        int                    delay;
    } row_t;

    logic                         aclk;
    logic                         aresetn;
    logic [`N_REGIONS-1:0]        s_req_valid;
    logic [`N_REGIONS-1:0]        s_req_ready;
    addr_t [`N_REGIONS-1:0]       s_req_addr;
    len_t [`N_REGIONS-1:0]        s_req_len;
    logic [`N_REGIONS-1:0]        s_req_last;
    logic                         m_req_valid;
    logic                         m_req_ready;
    addr_t                        m_req_addr;
    len_t                         m_req_len;
    logic                         m_req_last;
    logic                         m_rsp_done;
    logic [`N_REGIONS-1:0]        s_rsp_done;
    logic                         s_dat_valid;
    logic                         s_dat_ready;
    data_t                        s_dat_data;
    logic [`N_REGIONS-1:0]        m_dat_valid;
    logic [`N_REGIONS-1:0]        m_dat_ready;
    data_t [`N_REGIONS-1:0]       m_dat_data;
    logic [`N_REGIONS-1:0]        m_dat_last;

    row_t  rows [N_ROWS];
    // Expected requests in grant order
    vfid_t exp_vfid [MAX_REQ];
    blen_t exp_blen [MAX_REQ];
    logic  exp_last [MAX_REQ];
    int    n_exp;
    // Engine model bookkeeping
    vfid_t eng_vfid [MAX_REQ];
    blen_t eng_blen [MAX_REQ];
    int    eng_delay [MAX_REQ];
    int    n_acc;
    int    n_data_done;
    int    n_cmp;
    int    cur_stall;
    int    cur_delay;
    // Monitor progress
    int    g_idx;
    int    b_idx;
    int    r_idx;
    int    in_flight;
    int    beat_in_req;
    int    rcv_idx [`N_REGIONS];

    dma_mux_top u_dma_mux_top (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req_addr  (s_req_addr),
        .s_req_len   (s_req_len),
        .s_req_last  (s_req_last),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_addr  (m_req_addr),
        .m_req_len   (m_req_len),
        .m_req_last  (m_req_last),
        .m_rsp_done  (m_rsp_done),
        .s_rsp_done  (s_rsp_done),
        .s_dat_valid (s_dat_valid),
        .s_dat_ready (s_dat_ready),
        .s_dat_data  (s_dat_data),
        .m_dat_valid (m_dat_valid),
        .m_dat_ready (m_dat_ready),
        .m_dat_data  (m_dat_data),
        .m_dat_last  (m_dat_last)
    );

    // --------------------
    // Helpers

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic fail_run(input string msg);
        $display("At %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic vfid_check(input string what, input vfid_t got, input vfid_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic data_check(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic blen_check(input string what, input blen_t got, input blen_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic flag_check(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // Beats minus one for a byte length
    function automatic blen_t blen_of(input len_t len);
        len_t len_m1;
        len_m1 = len - len_t'(1);
        return blen_t'(len_m1 >> `BEAT_LOG_BITS);
    endfunction

    // Region number over a running per-region beat index
    function automatic data_t beat_word(input vfid_t v, input int idx);
        return {v, IDX_W'(idx)};
    endfunction

    function automatic vfid_t onehot_index(input logic [`N_REGIONS-1:0] bits);
        vfid_t idx;
        idx = '0;
        for (int i = 0; i < `N_REGIONS; i++) begin
            if (bits[i]) begin
                idx = vfid_t'(i);
            end
        end
        return idx;
    endfunction

    // --------------------
    // Clock and watchdog

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, requests or beats stopped moving", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Engine model

    // Request port with random stalls
    initial begin
        logic  fire;
        addr_t addr;
        len_t  len;
        m_req_ready = 1'b0;
        n_acc       = 0;
        forever begin
            @(negedge aclk);
            fire = m_req_valid && m_req_ready;
            addr = m_req_addr;
            len  = m_req_len;
            @(posedge aclk);
            if (fire) begin
                // Region rides in the top address bits
                eng_vfid[n_acc]  = addr[`ADDR_BITS-1 -: `N_REGIONS_BITS];
                eng_blen[n_acc]  = blen_of(len);
                eng_delay[n_acc] = cur_delay;
                n_acc++;
            end
            m_req_ready <= ($urandom_range(99) >= cur_stall);
        end
    end

    // Data beats in request order
    initial begin
        logic  fire;
        int    acc_seen;
        int    d_idx;
        blen_t beat;
        int    eng_idx [`N_REGIONS];
        s_dat_valid = 1'b0;
        s_dat_data  = '0;
        n_data_done = 0;
        d_idx       = 0;
        beat        = '0;
        for (int i = 0; i < `N_REGIONS; i++) begin
            eng_idx[i] = 0;
        end
        forever begin
            @(negedge aclk);
            fire     = s_dat_valid && s_dat_ready;
            acc_seen = n_acc;
            @(posedge aclk);
            if (fire) begin
                eng_idx[eng_vfid[d_idx]]++;
                if (beat == eng_blen[d_idx]) begin
                    d_idx++;
                    beat        = '0;
                    n_data_done = d_idx;
                end else begin
                    beat++;
                end
            end
            // A beat on offer stays until taken
            if (!s_dat_valid || fire) begin
                if (d_idx < acc_seen && $urandom_range(99) >= cur_stall) begin
                    s_dat_valid <= 1'b1;
                    s_dat_data  <= beat_word(eng_vfid[d_idx], eng_idx[eng_vfid[d_idx]]);
                end else begin
                    s_dat_valid <= 1'b0;
                end
            end
        end
    end

    // Completions follow the data and each waits out its delay
    initial begin
        int ready_n;
        int c_idx;
        int wait_cnt;
        m_rsp_done = 1'b0;
        n_cmp      = 0;
        c_idx      = 0;
        wait_cnt   = 0;
        forever begin
            @(negedge aclk);
            ready_n = n_data_done;
            @(posedge aclk);
            m_rsp_done <= 1'b0;
            if (c_idx < ready_n) begin
                if (wait_cnt >= eng_delay[c_idx]) begin
                    m_rsp_done <= 1'b1;
                    c_idx++;
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end
            n_cmp = c_idx;
        end
    end

    // Region side data back-pressure
    initial begin
        m_dat_ready = '0;
        forever begin
            @(posedge aclk);
            for (int i = 0; i < `N_REGIONS; i++) begin
                m_dat_ready[i] <= ($urandom_range(99) >= cur_stall);
            end
        end
    end

    // --------------------
    // Monitor sampled mid-cycle

    initial begin
        logic req_fire;
        logic fin;
        g_idx       = 0;
        b_idx       = 0;
        r_idx       = 0;
        in_flight   = 0;
        beat_in_req = 0;
        for (int i = 0; i < `N_REGIONS; i++) begin
            rcv_idx[i] = 0;
        end
        forever begin
            @(negedge aclk);
            if (aresetn) begin
                // Grants
                req_fire = m_req_valid && m_req_ready;
                if (req_fire) begin
                    if ($countones(s_req_ready) != 1) begin
                        fail_run("request taken without ready to exactly one region");
                    end
                    if (g_idx >= n_exp) begin
                        fail_run("engine got a request that no region made");
                    end
                    if (in_flight >= `N_OUTSTANDING) begin
                        fail_run("more requests in flight than the queues can hold");
                    end
                    vfid_check("grant region", onehot_index(s_req_ready), exp_vfid[g_idx]);
                    vfid_check("address region", m_req_addr[`ADDR_BITS-1 -: `N_REGIONS_BITS],
                               exp_vfid[g_idx]);
                    blen_check("request beats", blen_of(m_req_len), exp_blen[g_idx]);
                    flag_check("request last", m_req_last, 1'b1);
                    g_idx++;
                end else if (s_req_ready != '0) begin
                    fail_run("region ready given without an engine transfer");
                end
                in_flight = in_flight + int'(req_fire) - int'(m_rsp_done);

                // Data beats
                if ($countones(m_dat_valid) > 1) begin
                    fail_run("more than one region offered a data beat");
                end
                for (int i = 0; i < `N_REGIONS; i++) begin
                    if (m_dat_valid[i] && m_dat_ready[i]) begin
                        if (b_idx >= n_exp) begin
                            fail_run("data beat left over after all requests");
                        end
                        fin = (beat_in_req == int'(exp_blen[b_idx]));
                        vfid_check("beat region", vfid_t'(i), exp_vfid[b_idx]);
                        data_check("beat data", m_dat_data[i], beat_word(vfid_t'(i), rcv_idx[i]));
                        flag_check("beat last", m_dat_last[i], fin && exp_last[b_idx]);
                        rcv_idx[i]++;
                        if (fin) begin
                            b_idx++;
                            beat_in_req = 0;
                        end else begin
                            beat_in_req++;
                        end
                    end
                end

                // Completions
                if (m_rsp_done) begin
                    if ($countones(s_rsp_done) != 1) begin
                        fail_run("engine completion not passed to exactly one region");
                    end
                    vfid_check("done region", onehot_index(s_rsp_done), exp_vfid[r_idx]);
                    r_idx++;
                end else if (s_rsp_done != '0) begin
                    fail_run("region done pulse without an engine completion");
                end
            end
        end
    end

    // --------------------
    // Main sequence

    initial begin
        vfid_t                 r;
        vfid_t                 start;
        vfid_t                 rr_next;
        logic [`N_REGIONS-1:0] pending;
        logic [`N_REGIONS-1:0] granted;
        void'($urandom(32'h913b95db));
        aresetn     = 1'b0;
        s_req_valid = '0;
        s_req_addr  = '0;
        s_req_len   = '0;
        s_req_last  = '0;
        cur_stall   = 0;
        cur_delay   = 0;
        n_exp       = 0;
        rr_next     = '0;
        // Lengths and flags listed region 3 down to 0
        rows[0] = '{mask: 4'b1111, len: {16'd200, 16'd1, 16'd8, 16'd64}, last: 4'b0101,
                    stall: 0, delay: 0};
        rows[1] = '{mask: 4'b1010, len: {16'd17, 16'd1, 16'd9, 16'd1}, last: 4'b1010,
                    stall: 30, delay: 2};
        rows[2] = '{mask: 4'b0110, len: {16'd1, 16'd120, 16'd33, 16'd1}, last: 4'b0010,
                    stall: 50, delay: 1};
        // Completions held back so the next row hits the in-flight limit
        rows[3] = '{mask: 4'b1111, len: {16'd8, 16'd8, 16'd8, 16'd8}, last: 4'b1111,
                    stall: 0, delay: MAX_DELAY};
        rows[4] = '{mask: 4'b1011, len: {16'd72, 16'd1, 16'd40, 16'd24}, last: 4'b1001,
                    stall: 40, delay: 0};
        rows[5] = '{mask: 4'b1001, len: {16'd129, 16'd1, 16'd1, 16'd256}, last: 4'b1000,
                    stall: 20, delay: 3};

        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        flag_check("m_req_valid after reset", m_req_valid, 1'b0);
        flag_check("s_req_ready after reset", |s_req_ready, 1'b0);
        flag_check("s_dat_ready after reset", s_dat_ready, 1'b0);
        flag_check("s_rsp_done after reset", |s_rsp_done, 1'b0);
        flag_check("m_dat_valid after reset", |m_dat_valid, 1'b0);

        for (int row = 0; row < N_ROWS; row++) begin
            @(negedge aclk);
            cur_stall = rows[row].stall;
            cur_delay = rows[row].delay;
            @(posedge aclk);
            // Grants go round the mask from the region after the last winner
            start = rr_next;
            for (int k = 0; k < `N_REGIONS; k++) begin
                r = vfid_t'((int'(start) + k) % `N_REGIONS);
                if (rows[row].mask[r]) begin
                    exp_vfid[n_exp] = r;
                    exp_blen[n_exp] = blen_of(rows[row].len[r]);
                    exp_last[n_exp] = rows[row].last[r];
                    n_exp++;
                    rr_next = vfid_t'((int'(r) + 1) % `N_REGIONS);
                end
            end
            for (int i = 0; i < `N_REGIONS; i++) begin
                s_req_addr[i] <= {vfid_t'(i), ADDR_LOW'(row * 4096)};
            end
            s_req_len   <= rows[row].len;
            s_req_last  <= rows[row].last;
            s_req_valid <= rows[row].mask;
            pending = rows[row].mask;
            // Each region drops its request once taken
            while (pending != '0) begin
                @(negedge aclk);
                granted = s_req_valid & s_req_ready;
                @(posedge aclk);
                pending = pending & ~granted;
                s_req_valid <= pending;
            end
        end

        // Drain beats and completions
        while (b_idx != n_exp || r_idx != n_exp) begin
            @(negedge aclk);
        end
        repeat (8) @(negedge aclk);
        if (g_idx == n_exp && n_acc == n_exp && n_cmp == n_exp && in_flight == 0
                && !s_dat_valid) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Run ended with %0d of %0d requests accepted and %0d completed",
                     n_acc, n_exp, n_cmp);
            $display("Simulation failed");
            $fatal(1, "run ended incomplete");
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
dma_req_pkg.sv
stream_mux_pkg.sv
seq_fifo.sv
dma_arbiter.sv
stream_router.sv
dma_mux_top.sv
tb_dma_mux_top.sv

/* Makefile */
SIM  := obj_dir/Vtb_dma_mux_top
SRCS := $(filter-out +incdir+%,$(shell cat build.f))

.PHONY: run clean

# Rebuilt only when a source, the header or the file list changes
$(SIM): build.f $(SRCS) dma_macros.svh
	verilator --binary --timing -Wno-fatal --top-module tb_dma_mux_top -f build.f

# The log decides the result, not the simulator's exit status
run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@! grep -q "Simulation failed" sim.log
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
